//--- files.f
common/cpuIsaPkg.sv
common/cpuCtrlPkg.sv
logic/regFile.sv
execute/execUnit.sv
csr/csrUnit.sv
logic/memStage.sv
logic/cpuDatapath.sv
bench/cpuDatapath_chk.sv
bench/cpuDatapathTb.sv

//--- run.sh
#!/bin/sh
# build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module cpuDatapathTb \
   -f files.f -o simv
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "Done: no errors" sim.log; then
   exit 0
fi
echo "pass message missing from sim.log"
exit 1

//--- bench/cpuDatapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapathTb
   import cpuIsaPkg::*;
   import cpuCtrlPkg::*;
();

   localparam int resetCycles = 10;
   localparam int numInstr    = 2000;
   // every instruction takes one cycle, plus slack
   localparam int cycleLimit  = numInstr + 100 + resetCycles;

   logic                  clk;
   logic                  arstN;
   word                   instr;
   word                   pc;
   logic                  memWrite;
   logic                  memToReg;
   cpuCtrlPkg::branchType branchType;
   logic                  aluSrc;
   logic                  regWrite;
   logic                  jump;
   aluCtl                 aluControl;
   cpuCtrlPkg::immType    immType;
   logic                  csrEn;
   logic                  csrUimm;
   cpuCtrlPkg::csrOp      csrOp;
   word                   excpMepc;
   logic                  excpMepcEn;
   word                   dataAddr;
   word                   writeData;
   logic                  memWriteOut;
   word                   readData;
   logic                  wbEn;
   regIdx                 wbIdx;
   word                   wbData;
   word                   pcNext;
   logic                  pcSrc;
   word                   mtvec;
   word                   mepc;

   // reference state
   word   xr [0:31] = '{default: '0};
   word   csrs [0:3] = '{default: '0};
   word   modelMem [0:63];
   // memory behind the DUT port
   word   ram [0:63];
   word   lfsr = 32'h96233eca;
   int    errorCount = 0;
   int    cycleCount;
   word   expPcNext;
   logic  expPcSrc;
   // expected M and W stage results, oldest first
   logic  memWrQ [$];
   word   addrQ [$];
   word   dataQ [$];
   logic  wbEnQ [$];
   regIdx wbIdxQ [$];
   word   wbDataQ [$];
   word   mtvecQ [$];
   word   mepcQ [$];

   cpuDatapath DUT (.*);

   bind cpuDatapath cpuDatapath_chk chk (
      .clk(clk), .arstN(arstN), .wbEn(wbEn), .wbIdx(wbIdx), .memWriteOut(memWriteOut),
      .csrValid(csrValid), .pcSrc(pcSrc), .branchType(branchType), .jump(jump)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // data memory answers in the same cycle
   assign readData = ram[dataAddr[7:2]];

   always @(posedge clk) begin
      if (memWriteOut) begin
         ram[dataAddr[7:2]] <= writeData;
      end
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic word takeBits(int n);
      word  v;
      logic fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic word aluModel(aluCtl op, word a, word b);
      logic [4:0] sh;
      sh = b[4:0];
      case (op)
         aluAdd:  return a + b;
         aluSub:  return a - b;
         aluAnd:  return a & b;
         aluOr:   return a | b;
         aluXor:  return a ^ b;
         // signed order by flipping the sign bits
         aluSlt:  return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
         aluSltu: return {31'd0, a < b};
         aluSll:  return a << sh;
         aluSrl:  return a >> sh;
         default: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      endcase
   endfunction

   function automatic logic branchModel(cpuCtrlPkg::branchType bt, word a, word b);
      logic less;
      less = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
      case (bt)
         brEq:    return a == b;
         brNe:    return a != b;
         brLt:    return less;
         brGe:    return !less;
         brLtu:   return a < b;
         brGeu:   return !(a < b);
         default: return 1'b0;
      endcase
   endfunction

   // model slot of a csr, -1 when unknown
   function automatic int csrSlot(csrAddr addr);
      case (addr)
         csrMtvec:    return 0;
         csrMepc:     return 1;
         csrMscratch: return 2;
         csrMcause:   return 3;
         default:     return -1;
      endcase
   endfunction

   task automatic checkValue(string name, word got, word exp);
      if (got !== exp) begin
         errorCount++;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         $display("Done: errors found");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // random instruction into E, model runs it in program order
   task automatic issueNext(input logic bubble);
      int                    kind;
      int                    slot;
      regIdx                 rd;
      regIdx                 rs1;
      regIdx                 rs2;
      aluCtl                 op;
      cpuCtrlPkg::branchType bt;
      cpuCtrlPkg::csrOp      co;
      csrAddr                addr;
      logic                  uimm;
      logic                  excp;
      logic                  doWb;
      logic                  doStore;
      word                   imm;
      word                   res;
      word                   opnd;
      word                   pcNow;
      word                   nextPc;
      word                   excpVal;
      word                   stAddr;
      word                   stData;
      kind    = bubble ? 15 : int'(takeBits(4));
      // small indices so hazards come often
      rd      = 5'(takeBits(3));
      rs1     = 5'(takeBits(3));
      rs2     = 5'(takeBits(3));
      op      = 4'(takeBits(4) % 10);
      imm     = takeBits(12);
      imm     = {{20{imm[11]}}, imm[11:0]};
      pcNow   = takeBits(30) << 2;
      excp    = !bubble && (takeBits(5) == 32'd0);
      excpVal = takeBits(30) << 2;
      doWb    = 1'b0;
      doStore = 1'b0;
      res     = '0;
      stAddr  = '0;
      stData  = '0;
      nextPc  = pcNow + 32'd4;
      expPcSrc = 1'b0;
      // default is a register-register op with no write
      instr      <= {7'd0, rs2, rs1, 3'd0, rd, 7'h33};
      pc         <= pcNow;
      memWrite   <= 1'b0;
      memToReg   <= 1'b0;
      branchType <= brNone;
      aluSrc     <= 1'b0;
      regWrite   <= 1'b0;
      jump       <= 1'b0;
      aluControl <= op;
      immType    <= immI;
      csrEn      <= 1'b0;
      csrUimm    <= 1'b0;
      csrOp      <= csrW;
      excpMepcEn <= excp;
      excpMepc   <= excpVal;
      // exception capture lands before this instruction's csr access
      if (excp) begin
         csrs[1] = excpVal;
      end
      mtvecQ.push_back(csrs[0]);
      mepcQ.push_back(csrs[1]);
      case (kind)
         0, 1, 2, 3, 4: begin
            regWrite <= 1'b1;
            res  = aluModel(op, xr[rs1], xr[rs2]);
            doWb = 1'b1;
         end
         5, 6, 7: begin
            instr    <= {imm[11:0], rs1, 3'd0, rd, 7'h13};
            aluSrc   <= 1'b1;
            regWrite <= 1'b1;
            res  = aluModel(op, xr[rs1], imm);
            doWb = 1'b1;
         end
         8: begin
            // base x0, offset inside the 64-word memory
            imm = takeBits(6) << 2;
            instr      <= {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
            aluSrc     <= 1'b1;
            immType    <= immS;
            aluControl <= aluAdd;
            memWrite   <= 1'b1;
            doStore = 1'b1;
            stAddr  = imm;
            stData  = xr[rs2];
            modelMem[imm[7:2]] = xr[rs2];
         end
         9: begin
            imm = takeBits(6) << 2;
            instr      <= {imm[11:0], 5'd0, 3'd2, rd, 7'h03};
            aluSrc     <= 1'b1;
            aluControl <= aluAdd;
            memToReg   <= 1'b1;
            regWrite   <= 1'b1;
            res  = modelMem[imm[7:2]];
            doWb = 1'b1;
         end
         10, 11: begin
            bt  = 3'(takeBits(3) % 6 + 1);
            // even offset, 13 bits signed
            imm = imm << 1;
            instr      <= {imm[12], imm[10:5], rs2, rs1, 3'd0, imm[4:1], imm[11], 7'h63};
            immType    <= immB;
            branchType <= bt;
            aluControl <= aluSub;
            if (branchModel(bt, xr[rs1], xr[rs2])) begin
               nextPc = pcNow + imm;
            end
            expPcSrc = 1'b1;
         end
         12: begin
            instr      <= {imm[11:0], rs1, 3'd0, rd, 7'h67};
            aluSrc     <= 1'b1;
            aluControl <= aluAdd;
            jump       <= 1'b1;
            regWrite   <= 1'b1;
            nextPc   = (xr[rs1] + imm) & ~32'd1;
            res      = pcNow + 32'd4;
            doWb     = 1'b1;
            expPcSrc = 1'b1;
         end
         13, 14: begin
            case (takeBits(3))
               32'd0, 32'd4: addr = csrMtvec;
               32'd1:        addr = csrMepc;
               32'd2:        addr = csrMscratch;
               32'd3:        addr = csrMcause;
               default:      addr = 12'h7c0;
            endcase
            co   = 2'(takeBits(2) % 3 + 1);
            uimm = takeBits(1) != 32'd0;
            instr    <= {addr, rs1, 3'd1, rd, 7'h73};
            csrEn    <= 1'b1;
            csrUimm  <= uimm;
            csrOp    <= co;
            regWrite <= 1'b1;
            slot = csrSlot(addr);
            // old value comes back, unknown reads zero
            res  = (slot < 0) ? '0 : csrs[slot[1:0]];
            opnd = uimm ? {27'd0, rs1} : xr[rs1];
            if ((rs1 != 5'd0 || co == csrW) && slot >= 0) begin
               csrs[slot[1:0]] = (co == csrW) ? opnd :
                                 (co == csrS) ? (res | opnd) : (res & ~opnd);
            end
            doWb = 1'b1;
         end
         default: begin
         end
      endcase
      if (doWb && rd != 5'd0) begin
         xr[rd] = res;
      end
      expPcNext = nextPc;
      memWrQ.push_back(doStore);
      addrQ.push_back(stAddr);
      dataQ.push_back(stData);
      wbEnQ.push_back(doWb && (rd != 5'd0));
      wbIdxQ.push_back(rd);
      wbDataQ.push_back(res);
   endtask

   // E outputs of this cycle, M of the one before, W of two before
   task automatic checkCycle();
      logic  expWr;
      logic  expEn;
      regIdx expIdx;
      word   expAddr;
      word   expData;
      word   expWb;
      checkValue("pcNext", pcNext, expPcNext);
      checkValue("pcSrc", word'(pcSrc), word'(expPcSrc));
      expWr   = memWrQ.pop_front();
      expAddr = addrQ.pop_front();
      expData = dataQ.pop_front();
      checkValue("memWriteOut", word'(memWriteOut), word'(expWr));
      if (expWr) begin
         checkValue("dataAddr", dataAddr, expAddr);
         checkValue("writeData", writeData, expData);
      end
      expEn  = wbEnQ.pop_front();
      expIdx = wbIdxQ.pop_front();
      expWb  = wbDataQ.pop_front();
      checkValue("wbEn", word'(wbEn), word'(expEn));
      if (expEn) begin
         checkValue("wbIdx", word'(wbIdx), word'(expIdx));
         checkValue("wbData", wbData, expWb);
      end
      checkValue("mtvec", mtvec, mtvecQ.pop_front());
      checkValue("mepc", mepc, mepcQ.pop_front());
   endtask

   initial begin
      cycleCount = 0;
      forever begin
         @(posedge clk);
         cycleCount++;
         if (cycleCount > cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleLimit);
            $display("Done: errors found");
            $fatal(1, "timeout");
         end
      end
   end

   initial begin
      arstN      = 1'b0;
      instr      = '0;
      pc         = '0;
      memWrite   = 1'b0;
      memToReg   = 1'b0;
      branchType = brNone;
      aluSrc     = 1'b0;
      regWrite   = 1'b0;
      jump       = 1'b0;
      aluControl = aluAdd;
      immType    = immI;
      csrEn      = 1'b0;
      csrUimm    = 1'b0;
      csrOp      = csrW;
      excpMepc   = '0;
      excpMepcEn = 1'b0;
      // pattern over the full byte address
      for (int i = 0; i < 64; i++) begin
         ram[6'(i)]      = ((word'(i) << 2) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
         modelMem[6'(i)] = ram[6'(i)];
      end
      // pipeline is empty right after reset
      memWrQ.push_back(1'b0);
      addrQ.push_back('0);
      dataQ.push_back('0);
      mtvecQ.push_back('0);
      mepcQ.push_back('0);
      repeat (2) begin
         wbEnQ.push_back(1'b0);
         wbIdxQ.push_back('0);
         wbDataQ.push_back('0);
      end
      repeat (resetCycles) @(posedge clk);
      arstN <= 1'b1;
      // two trailing bubbles drain M and W
      for (int n = 0; n < numInstr + 2; n++) begin
         @(posedge clk);
         issueNext(n >= numInstr);
         @(negedge clk);
         checkCycle();
      end
      if (errorCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/cpuDatapath_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath_chk
   import cpuIsaPkg::*;
   import cpuCtrlPkg::*;
(
   input logic                  clk,
   input logic                  arstN,
   input logic                  wbEn,
   input regIdx                 wbIdx,
   input logic                  memWriteOut,
   input logic                  csrValid,
   input logic                  pcSrc,
   input cpuCtrlPkg::branchType branchType,
   input logic                  jump
);

   // sampled mid-cycle, flops already cleared by the async reset
   resetIdle: assert property (@(negedge clk)
      !arstN |-> (!wbEn && !memWriteOut && !csrValid))
      else $error("write strobes active while in reset");

   // x0 never shows up on the writeback bus
   noX0Write: assert property (@(posedge clk) disable iff (!arstN)
      wbEn |-> (wbIdx != '0))
      else $error("writeback enabled for register 0");

   // any branch type or jump, taken or not
   pcSrcRule: assert property (@(posedge clk) disable iff (!arstN)
      pcSrc == ((branchType != brNone) || jump))
      else $error("pcSrc does not follow branch type and jump");

endmodule

`default_nettype wire

//--- logic/cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath
   import cpuIsaPkg::*;
   import cpuCtrlPkg::*;
(
   input  logic                  clk,
   input  logic                  arstN,
   // EX stage instruction and control
   input  word                   instr,
   input  word                   pc,
   input  logic                  memWrite,
   input  logic                  memToReg,
   input  cpuCtrlPkg::branchType branchType,
   input  logic                  aluSrc,
   input  logic                  regWrite,
   input  logic                  jump,
   input  aluCtl                 aluControl,
   input  cpuCtrlPkg::immType    immType,
   input  logic                  csrEn,
   input  logic                  csrUimm,
   input  cpuCtrlPkg::csrOp      csrOp,
   // exception capture of mepc
   input  word                   excpMepc,
   input  logic                  excpMepcEn,
   // data memory
   output word                   dataAddr,
   output word                   writeData,
   output logic                  memWriteOut,
   input  word                   readData,
   // writeback, also the retire trace
   output logic                  wbEn,
   output regIdx                 wbIdx,
   output word                   wbData,
   output word                   pcNext,
   output logic                  pcSrc,
   output word                   mtvec,
   output word                   mepc
);

   word  rs1Data;
   word  rs2Data;
   logic fwdRs1;
   logic fwdRs2;
   word  fwdData;
   word  aluOut;
   word  storeData;
   word  rs1Value;
   word  csrRead;
   logic csrValid;

   // source indices straight from the E instruction
   regFile rf (
      .clk(clk), .arstN(arstN),
      .rs1Idx(instr[rs1High:rs1Low]), .rs2Idx(instr[rs2High:rs2Low]),
      .rs1Data(rs1Data), .rs2Data(rs2Data),
      .wrEn(wbEn), .wrIdx(wbIdx), .wrData(wbData)
   );

   execUnit ex (
      .instr(instr), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
      .fwdData(fwdData), .fwdRs1(fwdRs1), .fwdRs2(fwdRs2),
      .aluSrc(aluSrc), .jump(jump), .branchType(branchType),
      .aluControl(aluControl), .immType(immType),
      .aluOut(aluOut), .storeData(storeData), .pcNext(pcNext),
      .rs1Value(rs1Value), .pcSrc(pcSrc)
   );

   // runs beside the execute unit
   csrUnit csr (
      .clk(clk), .arstN(arstN), .instr(instr), .rs1Value(rs1Value),
      .csrEn(csrEn), .csrUimm(csrUimm), .csrOp(csrOp),
      .excpMepc(excpMepc), .excpMepcEn(excpMepcEn),
      .csrRead(csrRead), .csrValid(csrValid), .mtvec(mtvec), .mepc(mepc)
   );

   memStage mem (
      .clk(clk), .arstN(arstN), .instr(instr), .pc(pc),
      .aluOut(aluOut), .storeData(storeData),
      .memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite), .jump(jump),
      .csrRead(csrRead), .csrValid(csrValid), .readData(readData),
      .dataAddr(dataAddr), .writeData(writeData), .memWriteOut(memWriteOut),
      .fwdRs1(fwdRs1), .fwdRs2(fwdRs2), .fwdData(fwdData),
      .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData)
   );

endmodule

`default_nettype wire

//--- logic/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage
   import cpuIsaPkg::*;
(
   input  logic  clk,
   input  logic  arstN,
   input  word   instr,
   input  word   pc,
   input  word   aluOut,
   input  word   storeData,
   input  logic  memWrite,
   input  logic  memToReg,
   input  logic  regWrite,
   input  logic  jump,
   input  word   csrRead,
   input  logic  csrValid,
   input  word   readData,
   output word   dataAddr,
   output word   writeData,
   output logic  memWriteOut,
   output logic  fwdRs1,
   output logic  fwdRs2,
   output word   fwdData,
   output logic  wbEn,
   output regIdx wbIdx,
   output word   wbData
);

   logic  regWriteM;
   logic  memToRegM;
   logic  jumpM;
   word   aluOutM;
   word   storeDataM;
   word   pcPlus4M;
   regIdx rdM;
   word   resultM;

   // EX/MEM control, x0 writes never become writes
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         memWriteOut <= 1'b0;
         regWriteM   <= 1'b0;
         memToRegM   <= 1'b0;
         jumpM       <= 1'b0;
      end else begin
         memWriteOut <= memWrite;
         regWriteM   <= regWrite & (instr[rdHigh:rdLow] != '0);
         memToRegM   <= memToReg;
         jumpM       <= jump;
      end
   end

   // EX/MEM payload
   always_ff @(posedge clk) begin
      aluOutM    <= aluOut;
      storeDataM <= storeData;
      pcPlus4M   <= pc + 32'd4;
      rdM        <= instr[rdHigh:rdLow];
   end

   // memory port, answers in the same cycle
   assign dataAddr  = aluOutM;
   assign writeData = storeDataM;

   // csr read, then link address, then load, then alu
   assign resultM = csrValid  ? csrRead  :
                    jumpM     ? pcPlus4M :
                    memToRegM ? readData :
                                aluOutM;

   // forward to E when its sources hit the M destination
   assign fwdData = resultM;
   assign fwdRs1  = regWriteM & (rdM == instr[rs1High:rs1Low]);
   assign fwdRs2  = regWriteM & (rdM == instr[rs2High:rs2Low]);

   // MEM/WB
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wbEn <= 1'b0;
      end else begin
         wbEn <= regWriteM;
      end
   end

   always_ff @(posedge clk) begin
      wbIdx  <= rdM;
      wbData <= resultM;
   end

endmodule

`default_nettype wire

//--- csr/csrUnit.sv
`timescale 1ns/1ps
`default_nettype none

module csrUnit
   import cpuIsaPkg::*;
   import cpuCtrlPkg::*;
(
   input  logic              clk,
   input  logic              arstN,
   input  word               instr,
   input  word               rs1Value,
   input  logic              csrEn,
   input  logic              csrUimm,
   input  cpuCtrlPkg::csrOp  csrOp,
   input  word               excpMepc,
   input  logic              excpMepcEn,
   output word               csrRead,
   output logic              csrValid,
   output word               mtvec,
   output word               mepc
);

   logic             readEn;
   logic             writeEn;
   word              operand;
   logic             reqRead;
   logic             reqWrite;
   csrAddr           reqAddr;
   cpuCtrlPkg::csrOp reqOp;
   word              reqOperand;
   word              mscratch;
   word              mcause;
   word              oldValue;
   word              newValue;

   // E stage decode
   // rd == x0 means no read side effect
   assign readEn  = csrEn & (instr[rdHigh:rdLow] != '0);
   // set/clear with a zero source leave the csr alone
   assign writeEn = csrEn & ((instr[rs1High:rs1Low] != '0) | (csrOp == csrW));
   // uimm is the rs1 field, zero extended
   assign operand = csrUimm ? word'(instr[rs1High:rs1Low]) : rs1Value;

   // request register, E to M
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         reqRead  <= 1'b0;
         reqWrite <= 1'b0;
      end else begin
         reqRead  <= readEn;
         reqWrite <= writeEn;
      end
   end

   always_ff @(posedge clk) begin
      reqAddr    <= instr[csrHigh:csrLow];
      reqOp      <= csrOp;
      reqOperand <= operand;
   end

   // M stage read, unknown addresses read as zero
   always_comb begin
      case (reqAddr)
         csrMtvec:    oldValue = mtvec;
         csrMepc:     oldValue = mepc;
         csrMscratch: oldValue = mscratch;
         csrMcause:   oldValue = mcause;
         default:     oldValue = '0;
      endcase
   end

   always_comb begin
      case (reqOp)
         csrW:    newValue = reqOperand;
         csrS:    newValue = oldValue | reqOperand;
         csrC:    newValue = oldValue & ~reqOperand;
         default: newValue = oldValue;
      endcase
   end

   assign csrRead  = reqRead ? oldValue : '0;
   assign csrValid = reqRead;

   // write lands at the end of M
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         mtvec    <= '0;
         mepc     <= '0;
         mscratch <= '0;
         mcause   <= '0;
      end else begin
         if (reqWrite && (reqAddr == csrMtvec)) mtvec <= newValue;
         if (reqWrite && (reqAddr == csrMscratch)) mscratch <= newValue;
         if (reqWrite && (reqAddr == csrMcause)) mcause <= newValue;
         // exception capture beats the instruction write
         if (excpMepcEn) begin
            mepc <= excpMepc;
         end else if (reqWrite && (reqAddr == csrMepc)) begin
            mepc <= newValue;
         end
      end
   end

endmodule

`default_nettype wire

//--- execute/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit
   import cpuIsaPkg::*;
   import cpuCtrlPkg::*;
(
   input  word                   instr,
   input  word                   pc,
   input  word                   rs1Data,
   input  word                   rs2Data,
   input  word                   fwdData,
   input  logic                  fwdRs1,
   input  logic                  fwdRs2,
   input  logic                  aluSrc,
   input  logic                  jump,
   input  cpuCtrlPkg::branchType branchType,
   input  aluCtl                 aluControl,
   input  cpuCtrlPkg::immType    immType,
   output word                   aluOut,
   output word                   storeData,
   output word                   pcNext,
   output word                   rs1Value,
   output logic                  pcSrc
);

   word  opA;
   word  opB;
   word  aluB;
   word  imm;
   word  pcPlus4;
   word  pcBranch;
   logic taken;

   // MEM result wins, W bypass already folded into rs1Data/rs2Data
   assign opA = fwdRs1 ? fwdData : rs1Data;
   assign opB = fwdRs2 ? fwdData : rs2Data;

   // stores write the forwarded rs2, csr unit gets forwarded rs1
   assign storeData = opB;
   assign rs1Value  = opA;

   // sign-extended immediate per format
   always_comb begin
      case (immType)
         immI: imm = {{20{instr[31]}}, instr[31:20]};
         immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                      instr[11:8], 1'b0};
         immU: imm = {instr[31:12], 12'b0};
         immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                      instr[30:21], 1'b0};
         default: imm = '0;
      endcase
   end

   // second alu operand
   assign aluB = aluSrc ? imm : opB;

   always_comb begin
      case (aluControl)
         aluAdd:  aluOut = opA + aluB;
         aluSub:  aluOut = opA - aluB;
         aluAnd:  aluOut = opA & aluB;
         aluOr:   aluOut = opA | aluB;
         aluXor:  aluOut = opA ^ aluB;
         aluSlt:  aluOut = word'($signed(opA) < $signed(aluB));
         aluSltu: aluOut = word'(opA < aluB);
         // shift amount is the low five bits only
         aluSll:  aluOut = opA << aluB[4:0];
         aluSrl:  aluOut = opA >> aluB[4:0];
         aluSra:  aluOut = word'($signed(opA) >>> aluB[4:0]);
         default: aluOut = '0;
      endcase
   end

   // branch compare always on registers, never the immediate
   always_comb begin
      case (branchType)
         brNone:  taken = 1'b0;
         brEq:    taken = (opA == opB);
         brNe:    taken = (opA != opB);
         brLt:    taken = ($signed(opA) < $signed(opB));
         brGe:    taken = ($signed(opA) >= $signed(opB));
         brLtu:   taken = (opA < opB);
         brGeu:   taken = (opA >= opB);
         default: taken = 1'b0;
      endcase
   end

   // offsets are relative to the branch itself
   assign pcPlus4  = pc + 32'd4;
   assign pcBranch = pc + imm;

   // jump target comes out of the alu, bit 0 dropped as for jalr
   always_comb begin
      if (jump) begin
         pcNext = {aluOut[xlen-1:1], 1'b0};
      end else if (taken) begin
         pcNext = pcBranch;
      end else begin
         pcNext = pcPlus4;
      end
   end

   // any control transfer, taken or not
   assign pcSrc = (branchType != brNone) | jump;

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
   import cpuIsaPkg::*;
(
   input  logic  clk,
   input  logic  arstN,
   input  regIdx rs1Idx,
   input  regIdx rs2Idx,
   output word   rs1Data,
   output word   rs2Data,
   input  logic  wrEn,
   input  regIdx wrIdx,
   input  word   wrData
);

   // x0 has no storage
   word regs [1:31];

   // x0 reads zero, same-cycle write shows through
   function automatic word readPort(regIdx idx);
      word value;
      if (idx == '0) begin
         value = '0;
      end else if (wrEn && (wrIdx == idx)) begin
         value = wrData;
      end else begin
         value = regs[idx];
      end
      return value;
   endfunction

   always_comb begin
      rs1Data = readPort(rs1Idx);
      rs2Data = readPort(rs2Idx);
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrIdx != '0)) begin
         regs[wrIdx] <= wrData;
      end
   end

endmodule

`default_nettype wire

//--- common/cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

   // alu operation select
   typedef logic [3:0] aluCtl;
   localparam aluCtl aluAdd  = 4'd0;
   localparam aluCtl aluSub  = 4'd1;
   localparam aluCtl aluAnd  = 4'd2;
   localparam aluCtl aluOr   = 4'd3;
   localparam aluCtl aluXor  = 4'd4;
   localparam aluCtl aluSlt  = 4'd5;
   localparam aluCtl aluSltu = 4'd6;
   localparam aluCtl aluSll  = 4'd7;
   localparam aluCtl aluSrl  = 4'd8;
   localparam aluCtl aluSra  = 4'd9;

   // conditional branch kind, brNone for everything else
   typedef logic [2:0] branchType;
   localparam branchType brNone = 3'd0;
   localparam branchType brEq   = 3'd1;
   localparam branchType brNe   = 3'd2;
   localparam branchType brLt   = 3'd3;
   localparam branchType brGe   = 3'd4;
   localparam branchType brLtu  = 3'd5;
   localparam branchType brGeu  = 3'd6;

   // immediate format
   typedef logic [2:0] immType;
   localparam immType immI = 3'd0;
   localparam immType immS = 3'd1;
   localparam immType immB = 3'd2;
   localparam immType immU = 3'd3;
   localparam immType immJ = 3'd4;

   // csrrw / csrrs / csrrc, 0 is unused
   typedef logic [1:0] csrOp;
   localparam csrOp csrW = 2'd1;
   localparam csrOp csrS = 2'd2;
   localparam csrOp csrC = 2'd3;

endpackage

`default_nettype wire

//--- common/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

   // data path width
   localparam int xlen = 32;

   // data words and addresses
   typedef logic [xlen-1:0] word;
   // register file index
   typedef logic [4:0]      regIdx;
   // csr address space
   typedef logic [11:0]     csrAddr;

   // register fields of the instruction word
   localparam int rdLow   = 7;
   localparam int rdHigh  = 11;
   localparam int rs1Low  = 15;
   localparam int rs1High = 19;
   localparam int rs2Low  = 20;
   localparam int rs2High = 24;

   // csr number sits where the I-type immediate would be
   localparam int csrLow  = 20;
   localparam int csrHigh = 31;

   // machine trap setup and handling
   localparam csrAddr csrMtvec    = 12'h305;
   localparam csrAddr csrMscratch = 12'h340;
   localparam csrAddr csrMepc     = 12'h341;
   localparam csrAddr csrMcause   = 12'h342;

endpackage

`default_nettype wire
